//--- logic/nx_pkg.sv
// Shared widths, message command codes and header layouts for the node router
// Holds the header union read by the distributor and the local controller

`default_nettype none

package nx_pkg;

    // Width of one flit on every stream
    localparam int NX_BUS_W = 32;

    // Node position fields carried at the top of every header
    localparam int NX_ROW_W = 4;
    localparam int NX_COL_W = 4;

    // Instruction memory geometry, 1024 words of one flit each
    localparam int NX_ADDR_W    = 10;
    localparam int NX_MEM_DEPTH = 1 << NX_ADDR_W;

    // Signal bits held by the node and the width of an index into them
    localparam int NX_SIG_COUNT = 8;
    localparam int NX_SIG_IDX_W = $clog2(NX_SIG_COUNT);

    // Width of the command field and the spare bits left in each layout
    localparam int NX_CMD_W        = 2;
    localparam int NX_LOAD_SPARE_W = NX_BUS_W - NX_ROW_W - NX_COL_W - NX_CMD_W - NX_ADDR_W;
    localparam int NX_SIG_SPARE_W  = NX_BUS_W - NX_ROW_W - NX_COL_W - NX_CMD_W
                                   - NX_SIG_IDX_W - 1;

    // Message commands understood by the local controller
    typedef enum logic [NX_CMD_W-1:0] {
        NX_CMD_LOAD   = 2'd0,
        NX_CMD_SIGNAL = 2'd1
    } nx_cmd_t;

    // LOAD header, the payload flits that follow go to memory from start_addr on
    typedef struct packed {
        logic [NX_ROW_W-1:0]        row;
        logic [NX_COL_W-1:0]        col;
        nx_cmd_t                    cmd;
        logic [NX_ADDR_W-1:0]       start_addr;
        logic [NX_LOAD_SPARE_W-1:0] spare;
    } nx_load_hdr_t;

    // SIGNAL header, drives one signal bit to the given state
    typedef struct packed {
        logic [NX_ROW_W-1:0]       row;
        logic [NX_COL_W-1:0]       col;
        nx_cmd_t                   cmd;
        logic [NX_SIG_IDX_W-1:0]   index;
        logic                      state;
        logic [NX_SIG_SPARE_W-1:0] spare;
    } nx_sig_hdr_t;

    // Both layouts share row, column and command in the same bit positions
    typedef union packed {
        nx_load_hdr_t load;
        nx_sig_hdr_t  sig;
    } nx_msg_hdr_t;

endpackage

`default_nettype wire

//--- logic/nx_skid.sv
// Two-entry skid stage for one valid/ready flit stream
// Registers data, last and valid, and keeps the input ready registered too

`timescale 1ns/1ps
`default_nettype none

module nx_skid
    import nx_pkg::*;
(
      input  logic                clk
    , input  logic                rst
    // Upstream side
    , input  logic [NX_BUS_W-1:0] in_data
    , input  logic                in_last
    , input  logic                in_valid
    , output logic                in_ready
    // Downstream side
    , output logic [NX_BUS_W-1:0] out_data
    , output logic                out_last
    , output logic                out_valid
    , input  logic                out_ready
);

// The main entry drives the output, the spill entry catches one extra flit
logic                main_valid;
logic                spill_valid;
logic [NX_BUS_W-1:0] spill_data;
logic                spill_last;

logic in_fire;
logic main_load;

// Ready only looks at our own spill entry, never at out_ready
assign in_ready = ~spill_valid;
assign in_fire  = in_valid & in_ready;

// The main entry may take a new flit when it is empty or being drained
assign main_load = ~main_valid | out_ready;

assign out_valid = main_valid;

always_ff @(posedge clk, posedge rst) begin : p_ctrl
    if (rst) begin
        main_valid  <= 1'b0;
        spill_valid <= 1'b0;
    end else begin
        if (main_load) begin
            // The spill entry has priority since it holds the older flit
            main_valid  <= spill_valid | in_fire;
            spill_valid <= 1'b0;
        end else if (in_fire) begin
            // Output stalled while a flit arrives, so park it in the spill
            spill_valid <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin : p_payload
    if (main_load) begin
        out_data <= spill_valid ? spill_data : in_data;
        out_last <= spill_valid ? spill_last : in_last;
    end
    if (~main_load & in_fire) begin
        spill_data <= in_data;
        spill_last <= in_last;
    end
end

endmodule

`default_nettype wire

//--- logic/nx_distributor.sv
// Message distributor for one inbound stream
// Sends each whole message to the local port or the bypass path by its header

`timescale 1ns/1ps
`default_nettype none

module nx_distributor
    import nx_pkg::*;
(
      input  logic                clk
    , input  logic                rst
    // Position of this node in the grid
    , input  logic [NX_ROW_W-1:0] node_row
    , input  logic [NX_COL_W-1:0] node_col
    // Inbound stream from the ingress skid
    , input  logic [NX_BUS_W-1:0] in_data
    , input  logic                in_last
    , input  logic                in_valid
    , output logic                in_ready
    // Messages addressed to this node
    , output logic [NX_BUS_W-1:0] local_data
    , output logic                local_last
    , output logic                local_valid
    , input  logic                local_ready
    // Messages passing through to another node
    , output logic [NX_BUS_W-1:0] bypass_data
    , output logic                bypass_last
    , output logic                bypass_valid
    , input  logic                bypass_ready
);

// Set once a header has been accepted, cleared by the accepted last flit
logic m_lock;
// Steering held for the rest of the message, high means local
logic m_sel_local;

nx_msg_hdr_t hdr;
logic        hdr_local;
logic        route_local;
logic        in_fire;

// Row and column sit in the same place in either layout, so use the load view
assign hdr       = nx_msg_hdr_t'(in_data);
assign hdr_local = (hdr.load.row == node_row) && (hdr.load.col == node_col);

// While locked the stored choice wins, otherwise the presented header decides
assign route_local = m_lock ? m_sel_local : hdr_local;

// Both paths see the same flit, only the chosen one sees it as valid
assign local_data   = in_data;
assign local_last   = in_last;
assign local_valid  = in_valid & route_local;

assign bypass_data  = in_data;
assign bypass_last  = in_last;
assign bypass_valid = in_valid & ~route_local;

// Stall only on the path that this message is using
assign in_ready = route_local ? local_ready : bypass_ready;
assign in_fire  = in_valid & in_ready;

always_ff @(posedge clk, posedge rst) begin : p_steer
    if (rst) begin
        m_lock      <= 1'b0;
        m_sel_local <= 1'b0;
    end else if (in_fire) begin
        // A single-flit message never locks
        m_lock      <= ~in_last;
        m_sel_local <= route_local;
    end
end

endmodule

`default_nettype wire

//--- logic/nx_arbiter.sv
// Two-into-one stream arbiter
// Holds the chosen source for a whole message and alternates between messages

`timescale 1ns/1ps
`default_nettype none

module nx_arbiter
    import nx_pkg::*;
(
      input  logic                clk
    , input  logic                rst
    // Inbound stream A
    , input  logic [NX_BUS_W-1:0] inbound_a_data
    , input  logic                inbound_a_last
    , input  logic                inbound_a_valid
    , output logic                inbound_a_ready
    // Inbound stream B
    , input  logic [NX_BUS_W-1:0] inbound_b_data
    , input  logic                inbound_b_last
    , input  logic                inbound_b_valid
    , output logic                inbound_b_ready
    // Merged outbound stream
    , output logic [NX_BUS_W-1:0] outbound_data
    , output logic                outbound_last
    , output logic                outbound_valid
    , input  logic                outbound_ready
);

// Last source that presented a flit, low for A
logic m_active;
// High from the first presented flit until the last flit is taken
logic m_lock;

logic m_source;

// Locked keeps the same source, unlocked moves to the other source if it is waiting
assign m_source = m_lock   ? m_active
                : m_active ? ~inbound_a_valid
                           : inbound_b_valid;

// Selected source goes onto the outbound stream
assign outbound_data  = m_source ? inbound_b_data  : inbound_a_data;
assign outbound_last  = m_source ? inbound_b_last  : inbound_a_last;
assign outbound_valid = m_source ? inbound_b_valid : inbound_a_valid;

// Only the selected source sees ready
assign inbound_a_ready = outbound_ready & ~m_source;
assign inbound_b_ready = outbound_ready &  m_source;

always_ff @(posedge clk, posedge rst) begin : p_lock
    if (rst) begin
        m_active <= 1'b0;
        m_lock   <= 1'b0;
    end else if (outbound_valid) begin
        m_active <= m_source;
        // A stalled last flit keeps the lock so the source cannot change under it
        m_lock   <= ~(outbound_last & outbound_ready);
    end
end

endmodule

`default_nettype wire

//--- logic/nx_local_ctrl.sv
// Local message controller with the node's instruction memory and signal bits
// Decodes LOAD and SIGNAL headers and serves core fetches from the same port

`timescale 1ns/1ps
`default_nettype none

module nx_local_ctrl
    import nx_pkg::*;
(
      input  logic                    clk
    , input  logic                    rst
    // Merged local message stream
    , input  logic [NX_BUS_W-1:0]     msg_data
    , input  logic                    msg_last
    , input  logic                    msg_valid
    , output logic                    msg_ready
    // Core fetch port, data returns one cycle after the request
    , input  logic                    fetch_en
    , input  logic [NX_ADDR_W-1:0]    fetch_addr
    , output logic [NX_BUS_W-1:0]     fetch_data
    // Signal bits presented to the core
    , output logic [NX_SIG_COUNT-1:0] signals
);

// Single-port instruction memory
logic [NX_BUS_W-1:0] mem [NX_MEM_DEPTH];

// High when the next accepted flit starts a new message
logic                 m_expect_hdr;
// High while the payload of a LOAD message is arriving
logic                 m_in_load;
// Address for the next LOAD payload word
logic [NX_ADDR_W-1:0] m_wr_ptr;

nx_msg_hdr_t hdr;
logic        msg_fire;
logic        mem_we;

assign hdr = nx_msg_hdr_t'(msg_data);

// A fetch owns the memory port, so messages wait for that cycle
assign msg_ready = ~fetch_en;
assign msg_fire  = msg_valid & msg_ready;

// Payload flits of a LOAD are the only memory writes
assign mem_we = msg_fire & ~m_expect_hdr & m_in_load;

always_ff @(posedge clk, posedge rst) begin : p_ctrl
    if (rst) begin
        m_expect_hdr <= 1'b1;
        m_in_load    <= 1'b0;
        m_wr_ptr     <= '0;
        signals      <= '0;
    end else if (msg_fire) begin
        // The flit after a last flit is always a header
        m_expect_hdr <= msg_last;
        if (m_expect_hdr) begin
            m_in_load <= (hdr.load.cmd == NX_CMD_LOAD);
            if (hdr.load.cmd == NX_CMD_LOAD) begin
                m_wr_ptr <= hdr.load.start_addr;
            end
            // SIGNAL takes effect on the header itself, any later flits are dropped
            if (hdr.sig.cmd == NX_CMD_SIGNAL) begin
                signals[hdr.sig.index] <= hdr.sig.state;
            end
        end else if (m_in_load) begin
            // Pointer wraps naturally at the top of the memory
            m_wr_ptr <= m_wr_ptr + 1'b1;
        end
    end
end

// One access per cycle, a fetch read or a LOAD write
always_ff @(posedge clk) begin : p_mem
    if (fetch_en) begin
        fetch_data <= mem[fetch_addr];
    end else if (mem_we) begin
        mem[m_wr_ptr] <= msg_data;
    end
end

endmodule

`default_nettype wire

//--- logic/nx_router.sv
// Top level of the node message router
// Ingress skids, distributors, bypass and local arbiters, egress skid, local controller

`timescale 1ns/1ps
`default_nettype none

module nx_router
    import nx_pkg::*;
(
      input  logic                    clk
    , input  logic                    rst
    // Strapped position of this node
    , input  logic [NX_ROW_W-1:0]     node_row
    , input  logic [NX_COL_W-1:0]     node_col
    // Inbound stream A
    , input  logic [NX_BUS_W-1:0]     in_a_data
    , input  logic                    in_a_last
    , input  logic                    in_a_valid
    , output logic                    in_a_ready
    // Inbound stream B
    , input  logic [NX_BUS_W-1:0]     in_b_data
    , input  logic                    in_b_last
    , input  logic                    in_b_valid
    , output logic                    in_b_ready
    // Outbound stream carrying bypass traffic
    , output logic [NX_BUS_W-1:0]     outbound_data
    , output logic                    outbound_last
    , output logic                    outbound_valid
    , input  logic                    outbound_ready
    // Core side
    , input  logic                    fetch_en
    , input  logic [NX_ADDR_W-1:0]    fetch_addr
    , output logic [NX_BUS_W-1:0]     fetch_data
    , output logic [NX_SIG_COUNT-1:0] signals
);

// Registered inbound streams
logic [NX_BUS_W-1:0] ing_a_data, ing_b_data;
logic                ing_a_last, ing_b_last;
logic                ing_a_valid, ing_b_valid;
logic                ing_a_ready, ing_b_ready;

// Bypass paths out of each distributor and their merge
logic [NX_BUS_W-1:0] byp_a_data, byp_b_data, byp_m_data;
logic                byp_a_last, byp_b_last, byp_m_last;
logic                byp_a_valid, byp_b_valid, byp_m_valid;
logic                byp_a_ready, byp_b_ready, byp_m_ready;

// Local paths out of each distributor and their merge
logic [NX_BUS_W-1:0] loc_a_data, loc_b_data, loc_m_data;
logic                loc_a_last, loc_b_last, loc_m_last;
logic                loc_a_valid, loc_b_valid, loc_m_valid;
logic                loc_a_ready, loc_b_ready, loc_m_ready;

nx_skid ingress_a (
    .clk, .rst,
    .in_data  (in_a_data),  .in_last  (in_a_last),
    .in_valid (in_a_valid), .in_ready (in_a_ready),
    .out_data (ing_a_data),  .out_last  (ing_a_last),
    .out_valid(ing_a_valid), .out_ready (ing_a_ready)
);

nx_skid ingress_b (
    .clk, .rst,
    .in_data  (in_b_data),  .in_last  (in_b_last),
    .in_valid (in_b_valid), .in_ready (in_b_ready),
    .out_data (ing_b_data),  .out_last  (ing_b_last),
    .out_valid(ing_b_valid), .out_ready (ing_b_ready)
);

nx_distributor dist_a (
    .clk, .rst, .node_row, .node_col,
    .in_data     (ing_a_data),  .in_last     (ing_a_last),
    .in_valid    (ing_a_valid), .in_ready    (ing_a_ready),
    .local_data  (loc_a_data),  .local_last  (loc_a_last),
    .local_valid (loc_a_valid), .local_ready (loc_a_ready),
    .bypass_data (byp_a_data),  .bypass_last (byp_a_last),
    .bypass_valid(byp_a_valid), .bypass_ready(byp_a_ready)
);

nx_distributor dist_b (
    .clk, .rst, .node_row, .node_col,
    .in_data     (ing_b_data),  .in_last     (ing_b_last),
    .in_valid    (ing_b_valid), .in_ready    (ing_b_ready),
    .local_data  (loc_b_data),  .local_last  (loc_b_last),
    .local_valid (loc_b_valid), .local_ready (loc_b_ready),
    .bypass_data (byp_b_data),  .bypass_last (byp_b_last),
    .bypass_valid(byp_b_valid), .bypass_ready(byp_b_ready)
);

// Through traffic from both inputs shares the outbound stream
nx_arbiter bypass_arb (
    .clk, .rst,
    .inbound_a_data (byp_a_data),  .inbound_a_last (byp_a_last),
    .inbound_a_valid(byp_a_valid), .inbound_a_ready(byp_a_ready),
    .inbound_b_data (byp_b_data),  .inbound_b_last (byp_b_last),
    .inbound_b_valid(byp_b_valid), .inbound_b_ready(byp_b_ready),
    .outbound_data  (byp_m_data),  .outbound_last  (byp_m_last),
    .outbound_valid (byp_m_valid), .outbound_ready (byp_m_ready)
);

nx_skid egress (
    .clk, .rst,
    .in_data  (byp_m_data),  .in_last  (byp_m_last),
    .in_valid (byp_m_valid), .in_ready (byp_m_ready),
    .out_data (outbound_data),  .out_last (outbound_last),
    .out_valid(outbound_valid), .out_ready(outbound_ready)
);

// Messages for this node from both inputs share the local controller
nx_arbiter local_arb (
    .clk, .rst,
    .inbound_a_data (loc_a_data),  .inbound_a_last (loc_a_last),
    .inbound_a_valid(loc_a_valid), .inbound_a_ready(loc_a_ready),
    .inbound_b_data (loc_b_data),  .inbound_b_last (loc_b_last),
    .inbound_b_valid(loc_b_valid), .inbound_b_ready(loc_b_ready),
    .outbound_data  (loc_m_data),  .outbound_last  (loc_m_last),
    .outbound_valid (loc_m_valid), .outbound_ready (loc_m_ready)
);

nx_local_ctrl local_ctrl (
    .clk, .rst,
    .msg_data  (loc_m_data),  .msg_last (loc_m_last),
    .msg_valid (loc_m_valid), .msg_ready(loc_m_ready),
    .fetch_en, .fetch_addr, .fetch_data, .signals
);

endmodule

`default_nettype wire

//--- verif/nx_router_chk.sv
// Stream rule assertions for the skid stage
// Attached to every nx_skid instance by bind

`timescale 1ns/1ps
`default_nettype none

module nx_skid_chk
    import nx_pkg::*;
(
      input  logic                clk
    , input  logic                rst
    // Upstream handshake
    , input  logic                in_valid
    , input  logic                in_ready
    // Downstream side
    , input  logic [NX_BUS_W-1:0] out_data
    , input  logic                out_last
    , input  logic                out_valid
    , input  logic                out_ready
);

// Number of assertion failures seen in this stage
int unsigned fail_count = 0;

// Flits held by the stage, counted from the handshakes on both sides
logic [1:0] occupancy;

always_ff @(posedge clk, posedge rst) begin : p_occupancy
    if (rst) begin
        occupancy <= '0;
    end else begin
        occupancy <= occupancy + 2'(in_valid && in_ready) - 2'(out_valid && out_ready);
    end
end

// A presented flit may not be withdrawn before it is taken
a_valid_hold : assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid
) else begin
    fail_count = fail_count + 1;
    $error("skid output valid dropped while stalled");
end

// Data and last must hold still for as long as the output is stalled
a_data_stable : assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_data) && $stable(out_last)
) else begin
    fail_count = fail_count + 1;
    $error("skid output data or last changed while stalled");
end

// With two flits held there is nowhere to put another one
a_no_overflow : assert property (
    @(posedge clk) disable iff (rst)
    occupancy == 2'd2 |-> !(in_valid && in_ready)
) else begin
    fail_count = fail_count + 1;
    $error("skid accepted a flit with both entries full");
end

endmodule

bind nx_skid nx_skid_chk skid_chk (
    .clk, .rst, .in_valid, .in_ready,
    .out_data, .out_last, .out_valid, .out_ready
);

`default_nettype wire

//--- verif/nx_router_tb.sv
// Testbench for the node message router
// Random messages on both inputs, a reference model of bypass order,
// instruction memory and signal bits, and compare tasks for each result

`timescale 1ns/1ps
`default_nettype none

module nx_router_tb
    import nx_pkg::*;
();

// Position strapped onto the DUT
localparam logic [NX_ROW_W-1:0] NODE_ROW = 4'd5;
localparam logic [NX_COL_W-1:0] NODE_COL = 4'd9;
localparam int MSGS_PER_INPUT = 150;
localparam int FLIT_TIMEOUT   = 2000;
localparam int DRAIN_TIMEOUT  = 20000;

logic clk;
logic rst;

// Input streams, index 0 is A and index 1 is B
logic [NX_BUS_W-1:0] drv_data [2];
logic                drv_last [2];
logic                drv_valid [2];
logic                a_ready;
logic                b_ready;

logic [NX_BUS_W-1:0]     outbound_data;
logic                    outbound_last;
logic                    outbound_valid;
logic                    outbound_ready;
logic                    fetch_en;
logic [NX_ADDR_W-1:0]    fetch_addr;
logic [NX_BUS_W-1:0]     fetch_data;
logic [NX_SIG_COUNT-1:0] signals;

// Expected flits with last on top, split by input and by destination
logic [NX_BUS_W:0] byp_q_a [$];
logic [NX_BUS_W:0] byp_q_b [$];
logic [NX_BUS_W:0] loc_q_a [$];
logic [NX_BUS_W:0] loc_q_b [$];

// Model of the local controller state
logic [NX_BUS_W-1:0]     model_mem [NX_MEM_DEPTH];
logic [NX_SIG_COUNT-1:0] model_sig;
logic                    model_hdr_next;
logic                    model_in_load;
logic [NX_ADDR_W-1:0]    model_ptr;

// Source of the message in flight on each merged stream, -1 between messages
int byp_src;
int loc_src;

// Range of the most recent completed LOAD, used to aim fetches
logic [NX_ADDR_W-1:0] load_start;
int                   load_count;
logic [NX_ADDR_W-1:0] last_load_start;
int                   last_load_len;

logic                fetch_pending;
logic [NX_BUS_W-1:0] fetch_exp;
int                  error_count;

nx_router nx_router_i (
    .clk, .rst,
    .node_row  (NODE_ROW),     .node_col  (NODE_COL),
    .in_a_data (drv_data[0]),  .in_a_last (drv_last[0]),
    .in_a_valid(drv_valid[0]), .in_a_ready(a_ready),
    .in_b_data (drv_data[1]),  .in_b_last (drv_last[1]),
    .in_b_valid(drv_valid[1]), .in_b_ready(b_ready),
    .outbound_data, .outbound_last, .outbound_valid, .outbound_ready,
    .fetch_en, .fetch_addr, .fetch_data, .signals
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_flit(input string name, input logic [NX_BUS_W-1:0] exp_data,
                          input logic exp_last, input logic [NX_BUS_W-1:0] act_data,
                          input logic act_last);
    if (act_data !== exp_data || act_last !== exp_last) begin
        abort_run($sformatf("MISMATCH %s expected %h last %b actual %h last %b",
                            name, exp_data, exp_last, act_data, act_last));
    end
endtask

task automatic check_word(input string name, input logic [NX_BUS_W-1:0] exp_word,
                          input logic [NX_BUS_W-1:0] act_word);
    if (act_word !== exp_word) begin
        abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_word, act_word));
    end
endtask

task automatic check_signals(input string name, input logic [NX_SIG_COUNT-1:0] exp_sig,
                             input logic [NX_SIG_COUNT-1:0] act_sig);
    if (act_sig !== exp_sig) begin
        abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp_sig, act_sig));
    end
endtask

task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
    if (act_bit !== exp_bit) begin
        abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp_bit, act_bit));
    end
endtask

// A flit taken from the outbound stream must continue the message in flight
task automatic take_bypass(input logic [NX_BUS_W-1:0] act_data, input logic act_last);
    logic [NX_BUS_W:0] exp;
    string             name;
    if (byp_src < 0) begin
        // A new message starts, it has to be the front of one queue
        if (byp_q_a.size() > 0 && byp_q_a[0] === {act_last, act_data}) begin
            byp_src = 0;
        end else if (byp_q_b.size() > 0 && byp_q_b[0] === {act_last, act_data}) begin
            byp_src = 1;
        end else begin
            abort_run($sformatf("Outbound flit %h starts no expected bypass message",
                                act_data));
        end
    end
    if (byp_src == 0) begin
        name = "bypass A";
        exp  = byp_q_a.pop_front();
    end else begin
        name = "bypass B";
        if (byp_q_b.size() == 0) begin
            abort_run("Outbound stream carried a flit with no bypass message pending");
        end
        exp = byp_q_b.pop_front();
    end
    check_flit(name, exp[NX_BUS_W-1:0], exp[NX_BUS_W], act_data, act_last);
    if (exp[NX_BUS_W]) begin
        byp_src = -1;
    end
endtask

// Applies one local flit to the model in the order the controller takes them
task automatic take_local(input int src, input logic [NX_BUS_W-1:0] act_data,
                          input logic act_last);
    logic [NX_BUS_W:0] exp;
    nx_msg_hdr_t       hdr;
    string             name;
    if (loc_src >= 0 && loc_src != src) begin
        abort_run("Local messages from inputs A and B were interleaved");
    end
    if (src == 0) begin
        name = "local A";
        if (loc_q_a.size() == 0) begin
            abort_run("Input A sent a local flit with no local message pending");
        end
        exp = loc_q_a.pop_front();
    end else begin
        name = "local B";
        if (loc_q_b.size() == 0) begin
            abort_run("Input B sent a local flit with no local message pending");
        end
        exp = loc_q_b.pop_front();
    end
    check_flit(name, exp[NX_BUS_W-1:0], exp[NX_BUS_W], act_data, act_last);
    hdr = exp[NX_BUS_W-1:0];
    if (model_hdr_next) begin
        model_in_load = (hdr.load.cmd == NX_CMD_LOAD);
        if (model_in_load) begin
            model_ptr  = hdr.load.start_addr;
            load_start = hdr.load.start_addr;
            load_count = 0;
        end else if (hdr.sig.cmd == NX_CMD_SIGNAL) begin
            model_sig[hdr.sig.index] = hdr.sig.state;
        end
    end else if (model_in_load) begin
        // Payload words land at consecutive addresses and wrap at the top
        model_mem[model_ptr] = exp[NX_BUS_W-1:0];
        model_ptr            = model_ptr + 1'b1;
        load_count++;
    end
    model_hdr_next = exp[NX_BUS_W];
    loc_src        = exp[NX_BUS_W] ? -1 : src;
    if (exp[NX_BUS_W] && model_in_load && load_count > 0) begin
        last_load_start = load_start;
        last_load_len   = load_count;
    end
endtask

// Builds random messages for one input and drives them flit by flit
task automatic send_messages(input int port);
    logic [NX_BUS_W:0] msg [$];
    nx_msg_hdr_t       hdr;
    nx_load_hdr_t      lhdr;
    nx_sig_hdr_t       shdr;
    int                kind;
    int                len;
    int                wait_cnt;
    logic              accepted;
    logic              is_local;
    for (int m = 0; m < MSGS_PER_INPUT; m++) begin
        msg.delete();
        kind = $urandom % 3;
        len  = 1 + $urandom % 6;
        is_local = (kind != 0);
        if (kind == 0) begin
            // Through traffic for any position except this node
            hdr = $urandom;
            while (hdr.load.row == NODE_ROW && hdr.load.col == NODE_COL) begin
                hdr = $urandom;
            end
        end else if (kind == 1) begin
            lhdr.row = NODE_ROW;
            lhdr.col = NODE_COL;
            lhdr.cmd = NX_CMD_LOAD;
            // Mostly a few low addresses so LOADs overlap, sometimes near the top to wrap
            if ($urandom % 4 == 0) begin
                lhdr.start_addr = NX_ADDR_W'(NX_MEM_DEPTH - 4 + $urandom % 4);
            end else begin
                lhdr.start_addr = NX_ADDR_W'($urandom % 24);
            end
            lhdr.spare = $urandom;
            hdr = lhdr;
        end else begin
            shdr.row   = NODE_ROW;
            shdr.col   = NODE_COL;
            shdr.cmd   = NX_CMD_SIGNAL;
            shdr.index = $urandom;
            shdr.state = $urandom;
            shdr.spare = $urandom;
            hdr = shdr;
        end
        msg.push_back({len == 1, hdr});
        for (int i = 1; i < len; i++) begin
            msg.push_back({i == len - 1, NX_BUS_W'($urandom)});
        end
        foreach (msg[i]) begin
            if (port == 0 && is_local) loc_q_a.push_back(msg[i]);
            if (port == 0 && !is_local) byp_q_a.push_back(msg[i]);
            if (port == 1 && is_local) loc_q_b.push_back(msg[i]);
            if (port == 1 && !is_local) byp_q_b.push_back(msg[i]);
        end
        foreach (msg[i]) begin
            if ($urandom % 4 == 0) begin
                drv_valid[port] <= 1'b0;
                repeat (1 + $urandom % 3) @(posedge clk);
            end
            drv_data[port]  <= msg[i][NX_BUS_W-1:0];
            drv_last[port]  <= msg[i][NX_BUS_W];
            drv_valid[port] <= 1'b1;
            accepted = 1'b0;
            wait_cnt = 0;
            while (!accepted) begin
                @(negedge clk);
                accepted = (port == 0) ? a_ready : b_ready;
                wait_cnt++;
                if (!accepted && wait_cnt > FLIT_TIMEOUT) begin
                    abort_run($sformatf("Input %0d accepted no flit within %0d cycles",
                                        port, FLIT_TIMEOUT));
                end
                @(posedge clk);
            end
        end
    end
    drv_valid[port] <= 1'b0;
endtask

// Outbound sink and core fetch port, both random every cycle
always @(posedge clk) begin : core_and_sink
    if (!rst) begin
        outbound_ready <= ($urandom % 4) != 0;
        fetch_en       <= ($urandom % 3) == 0;
        if (last_load_len > 0 && ($urandom % 4) != 0) begin
            fetch_addr <= last_load_start + NX_ADDR_W'($urandom % last_load_len);
        end else begin
            fetch_addr <= NX_ADDR_W'($urandom);
        end
    end
end

// Everything is sampled half a cycle before the edge it takes effect on
always @(negedge clk) begin : monitor
    if (!rst) begin
        if (nx_router_i.ingress_a.skid_chk.fail_count != 0 ||
            nx_router_i.ingress_b.skid_chk.fail_count != 0 ||
            nx_router_i.egress.skid_chk.fail_count != 0) begin
            abort_run("A stream rule assertion failed in one of the skid stages");
        end
        if (fetch_pending) begin
            check_word("fetch", fetch_exp, fetch_data);
        end
        // A fetch and a LOAD write never share an edge, so the model is current here
        fetch_pending = fetch_en;
        fetch_exp     = model_mem[fetch_addr];
        check_signals("signals", model_sig, signals);
        if (outbound_valid && outbound_ready) begin
            take_bypass(outbound_data, outbound_last);
        end
        if (nx_router_i.loc_a_valid && nx_router_i.loc_a_ready) begin
            take_local(0, nx_router_i.loc_a_data, nx_router_i.loc_a_last);
        end
        if (nx_router_i.loc_b_valid && nx_router_i.loc_b_ready) begin
            take_local(1, nx_router_i.loc_b_data, nx_router_i.loc_b_last);
        end
    end
end

initial begin : main
    int wait_cnt;
    void'($urandom(92284));
    rst            = 1'b1;
    drv_data[0]    = '0;
    drv_data[1]    = '0;
    drv_last[0]    = 1'b0;
    drv_last[1]    = 1'b0;
    drv_valid[0]   = 1'b0;
    drv_valid[1]   = 1'b0;
    outbound_ready = 1'b0;
    fetch_en       = 1'b0;
    fetch_addr     = '0;
    model_sig      = '0;
    model_hdr_next = 1'b1;
    model_in_load  = 1'b0;
    model_ptr      = '0;
    byp_src        = -1;
    loc_src        = -1;
    load_start      = '0;
    load_count      = 0;
    last_load_start = '0;
    last_load_len   = 0;
    fetch_pending   = 1'b0;
    fetch_exp       = '0;
    error_count     = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // Idle outputs right after reset, before any flit is driven
    @(negedge clk);
    check_bit("outbound_valid after reset", 1'b0, outbound_valid);
    check_signals("signals after reset", '0, signals);
    @(posedge clk);
    fork
        send_messages(0);
        send_messages(1);
    join
    wait_cnt = 0;
    while (byp_q_a.size() + byp_q_b.size() + loc_q_a.size() + loc_q_b.size() != 0) begin
        @(posedge clk);
        wait_cnt++;
        if (wait_cnt > DRAIN_TIMEOUT) begin
            abort_run("Expected messages were still pending after the drain timeout");
        end
    end
    // A few more cycles so the last fetches get compared
    repeat (8) @(posedge clk);
    if (error_count == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- nx_router.f
logic/nx_pkg.sv
logic/nx_skid.sv
logic/nx_distributor.sv
logic/nx_arbiter.sv
logic/nx_local_ctrl.sv
logic/nx_router.sv
verif/nx_router_chk.sv
verif/nx_router_tb.sv
